//--- video_line_out.f
+incdir+include
source/video_pkg.sv
source/pixel_writer.sv
source/frame_ram.sv
source/ram_to_video.sv
source/video_line_out_top.sv
tests/video_line_out_checker.sv
tests/video_line_out_tb.sv

//--- tests/video_line_out_tb.sv
`include "video_geometry.svh"

module video_line_out_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int line_length  = `line_length;
    localparam int ram_lines    = `ram_lines;
    localparam int words        = line_length * ram_lines;
    localparam int h_total      = `h_total;
    localparam int h_visible    = `h_visible;
    localparam int h_offset     = `h_offset;
    localparam int h_sync_start = `h_sync_start;
    localparam int h_sync_width = `h_sync_width;
    localparam int v_total      = `v_total;
    localparam int v_visible    = `v_visible;
    localparam int v_offset     = `v_offset;
    localparam int v_sync_line  = `v_sync_line;
    localparam logic sync_idle  = !video_pkg::sync_active;
    localparam int restart_timeout  = 200;
    localparam int mid_frame_cycles = 30;
    localparam int test_count       = 5;

    typedef struct {
        string name;
        bit    doubler;
        bit    scanline;
        bit    mode_change; // flip line_doubler partway through the frame
        int    pixels;
    } test_row_t;

    test_row_t test_table[test_count] = '{
        '{"plain",             1'b0, 1'b0, 1'b0, 64},
        '{"doubled",           1'b1, 1'b0, 1'b0, 64},
        '{"scanlines",         1'b0, 1'b1, 1'b0, 64},
        '{"doubled_scanlines", 1'b1, 1'b1, 1'b0, 64},
        '{"mode_change",       1'b0, 1'b1, 1'b1, 64}
    };

    logic                              clock;
    logic                              combined_reset;
    logic                              pixel_strobe;
    logic [video_pkg::pixel_width-1:0] pixel_data;
    logic                              frame_start;
    logic                              line_doubler;
    logic                              scanline_enable;
    logic [video_pkg::pixel_width-1:0] video_out;
    logic                              hsync;
    logic                              vsync;
    logic                              draw_area;
    logic                              restart;

    logic [video_pkg::pixel_width-1:0] model [words]; // what the buffer should hold
    logic [31:0] lfsr_state = 32'h382d;
    string       test_name;
    bit          mode_doubler;
    bit          mode_scanline;
    int          sent_count;

    video_line_out_top dut (
        .clock           (clock),
        .combined_reset  (combined_reset),
        .pixel_strobe    (pixel_strobe),
        .pixel_data      (pixel_data),
        .frame_start     (frame_start),
        .line_doubler    (line_doubler),
        .scanline_enable (scanline_enable),
        .video_out       (video_out),
        .hsync           (hsync),
        .vsync           (vsync),
        .draw_area       (draw_area),
        .restart         (restart)
    );

    always #4 clock = ~clock;

    task automatic give_up(input string reason);
        $display("%s (test %s)", reason, test_name);
        $display("=== FAIL ===");
        $fatal(1);
    endtask

    task automatic check_value(input string signal_name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Fail %s %s: expected %h, actual %h", test_name, signal_name,
                     expected, actual);
            $display("=== FAIL ===");
            $fatal(1);
        end
    endtask

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    function automatic logic [video_pkg::pixel_width-1:0] random_pixel();
        logic [video_pkg::pixel_width-1:0] word;
        word = '0;
        for (int i = 0; i < video_pkg::pixel_width; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            word = {word[video_pkg::pixel_width-2:0], lfsr_state[0]};
        end
        return word;
    endfunction

    function automatic logic [video_pkg::pixel_width-1:0] expected_video(input int x, input int y);
        logic [video_pkg::pixel_width-1:0] word;
        logic [video_pkg::pixel_width-1:0] keep_mask;
        int row;
        if (x < h_offset || x >= h_visible - h_offset
                || y < v_offset || y >= v_visible - v_offset) begin
            return '0;
        end
        row  = mode_doubler ? (y >> 1) : (y - v_offset);
        word = model[(row % ram_lines) * line_length + x - h_offset];
        if (mode_scanline && y % 2 == 1) begin
            // clear the bit each channel gets from its upper neighbour
            for (int i = 0; i < video_pkg::pixel_width; i++) begin
                keep_mask[i] = (i % video_pkg::channel_width) != video_pkg::channel_width - 1;
            end
            word = (word >> 1) & keep_mask;
        end
        return word;
    endfunction

    task automatic reset_dut();
        @(posedge clock);
        combined_reset  <= 1'b1;
        line_doubler    <= mode_doubler; // edge detector settles under reset
        scanline_enable <= mode_scanline;
        repeat (3) @(posedge clock);
        combined_reset  <= 1'b0;
    endtask

    task automatic pulse_frame_start();
        @(posedge clock);
        frame_start <= 1'b1;
        @(posedge clock);
        frame_start <= 1'b0;
    endtask

    task automatic send_pixels(input int count);
        logic [video_pkg::pixel_width-1:0] word;
        for (int i = 0; i < count; i++) begin
            word = random_pixel();
            model[i % words] = word;
            @(posedge clock);
            pixel_strobe <= 1'b1;
            pixel_data   <= word;
            sent_count++;
        end
        @(posedge clock);
        pixel_strobe <= 1'b0;
    endtask

    task automatic check_idle(input int cycles);
        for (int n = 0; n < cycles; n++) begin
            @(negedge clock);
            check_value("restart", 1'b0, restart);
            check_value("draw_area", 1'b0, draw_area);
            check_value("video_out", '0, video_out);
            check_value("hsync", sync_idle, hsync);
            check_value("vsync", sync_idle, vsync);
        end
    endtask

    task automatic wait_restart();
        int cycles;
        cycles = 0;
        @(negedge clock);
        while (restart !== 1'b1) begin
            if (cycles == restart_timeout) begin
                give_up("timed out waiting for restart");
            end
            cycles++;
            @(negedge clock);
        end
        if (sent_count < line_length) begin
            give_up("restart came before a full line of pixels was written");
        end
    endtask

    task automatic check_frame();
        int x;
        int y;
        logic in_sync;
        x = h_offset;
        y = v_offset;
        repeat (2) @(negedge clock); // first window pixel
        for (int n = 0; n < h_total * v_total; n++) begin
            in_sync = x >= h_sync_start && x < h_sync_start + h_sync_width;
            check_value($sformatf("video_out at (%0d,%0d)", x, y), expected_video(x, y),
                        video_out);
            check_value("draw_area", x < h_visible && y < v_visible, draw_area);
            check_value("hsync", in_sync ? video_pkg::sync_active : sync_idle, hsync);
            check_value("vsync", (y == v_sync_line) ? video_pkg::sync_active : sync_idle, vsync);
            x++;
            if (x == h_total) begin
                x = 0;
                y = (y == v_total - 1) ? 0 : y + 1;
            end
            @(negedge clock);
        end
    endtask

    task automatic change_mode_mid_frame();
        repeat (mid_frame_cycles) @(negedge clock);
        @(posedge clock);
        mode_doubler = !mode_doubler;
        line_doubler <= mode_doubler;
        repeat (4) @(negedge clock); // edge detector plus output register
        check_idle(40);
    endtask

    task automatic run_frame(input int count, input bit interrupt);
        sent_count = 0;
        pulse_frame_start();
        fork
            send_pixels(count);
            begin
                wait_restart();
                if (interrupt) begin
                    change_mode_mid_frame();
                end else begin
                    check_frame();
                end
            end
        join
    endtask

    always @(negedge clock) begin
        if (dut.video.protocol_checker.failure_count != 0) begin
            give_up("an assertion in the protocol checker failed");
        end
    end

    initial begin
        clock           = 1'b0;
        combined_reset  = 1'b1;
        pixel_strobe    = 1'b0;
        pixel_data      = '0;
        frame_start     = 1'b0;
        line_doubler    = 1'b0;
        scanline_enable = 1'b0;
        mode_doubler    = 1'b0;
        mode_scanline   = 1'b0;
        sent_count      = 0;
        test_name       = "reset_state";

        reset_dut();
        check_idle(5);
        pulse_frame_start();
        send_pixels(line_length - 1); // one short of a line
        check_idle(20);

        for (int t = 0; t < test_count; t++) begin
            test_name     = test_table[t].name;
            mode_doubler  = test_table[t].doubler;
            mode_scanline = test_table[t].scanline;
            reset_dut();
            run_frame(test_table[t].pixels, test_table[t].mode_change);
            if (test_table[t].mode_change) begin
                run_frame(test_table[t].pixels, 1'b0);
            end
        end

        repeat (2) @(negedge clock);
        if (dut.video.protocol_checker.failure_count != 0) begin
            $display("=== FAIL ===");
            $fatal(1);
        end else begin
            $display("=== PASS ===");
            $finish;
        end
    end

endmodule

//--- tests/video_line_out_checker.sv
module video_line_out_checker (
    input logic                               clock,
    input logic                               combined_reset,
    input logic                               restart,
    input logic                               draw_area,
    input logic                               hsync,
    input logic [video_pkg::pixel_width-1:0]  video_out
);

    timeunit 1ns;
    timeprecision 100ps;

    int failure_count = 0; // read by the testbench

    restart_single: assert property (@(posedge clock) disable iff (combined_reset)
        restart |=> !restart)
        else begin
            $error("restart stayed high for two cycles");
            failure_count++;
        end

    // border and blanking carry no colour
    blank_is_black: assert property (@(posedge clock) disable iff (combined_reset)
        !draw_area |-> video_out == '0)
        else begin
            $error("video_out not zero outside the draw area");
            failure_count++;
        end

    no_sync_in_picture: assert property (@(posedge clock) disable iff (combined_reset)
        draw_area |-> hsync != video_pkg::sync_active)
        else begin
            $error("hsync active inside the draw area");
            failure_count++;
        end

endmodule

bind ram_to_video video_line_out_checker protocol_checker (
    .clock          (clock),
    .combined_reset (combined_reset),
    .restart        (restart),
    .draw_area      (draw_area),
    .hsync          (hsync),
    .video_out      (video_out)
);

//--- source/video_line_out_top.sv
`include "video_geometry.svh"

module video_line_out_top #(
    parameter int line_length  = `line_length,
    parameter int ram_lines    = `ram_lines,
    parameter int h_total      = `h_total,
    parameter int h_visible    = `h_visible,
    parameter int h_offset     = `h_offset,
    parameter int h_sync_start = `h_sync_start,
    parameter int h_sync_width = `h_sync_width,
    parameter int v_total      = `v_total,
    parameter int v_visible    = `v_visible,
    parameter int v_offset     = `v_offset,
    parameter int v_sync_line  = `v_sync_line
) (
    input  logic                               clock,
    input  logic                               combined_reset,
    input  logic                               pixel_strobe,
    input  logic [video_pkg::pixel_width-1:0]  pixel_data,
    input  logic                               frame_start,
    input  logic                               line_doubler,
    input  logic                               scanline_enable,
    output logic [video_pkg::pixel_width-1:0]  video_out,
    output logic                               hsync,
    output logic                               vsync,
    output logic                               draw_area,
    output logic                               restart
);

    localparam int address_bits = $clog2(line_length * ram_lines);

    logic                              write_enable;
    logic [address_bits-1:0]           write_address;
    logic [video_pkg::pixel_width-1:0] write_data;
    logic                              start_trigger;
    logic [address_bits-1:0]           read_address;
    logic [video_pkg::pixel_width-1:0] read_data;

    pixel_writer #(
        .line_length (line_length),
        .ram_lines   (ram_lines)
    ) writer (
        .clock          (clock),
        .combined_reset (combined_reset),
        .pixel_strobe   (pixel_strobe),
        .pixel_data     (pixel_data),
        .frame_start    (frame_start),
        .write_enable   (write_enable),
        .write_address  (write_address),
        .write_data     (write_data),
        .start_trigger  (start_trigger)
    );

    frame_ram #(
        .line_length (line_length),
        .ram_lines   (ram_lines)
    ) buffer (
        .clock         (clock),
        .write_enable  (write_enable),
        .write_address (write_address),
        .write_data    (write_data),
        .read_address  (read_address),
        .read_data     (read_data)
    );

    ram_to_video #(
        .line_length  (line_length),
        .ram_lines    (ram_lines),
        .h_total      (h_total),
        .h_visible    (h_visible),
        .h_offset     (h_offset),
        .h_sync_start (h_sync_start),
        .h_sync_width (h_sync_width),
        .v_total      (v_total),
        .v_visible    (v_visible),
        .v_offset     (v_offset),
        .v_sync_line  (v_sync_line)
    ) video (
        .clock           (clock),
        .combined_reset  (combined_reset),
        .start_trigger   (start_trigger),
        .line_doubler    (line_doubler),
        .scanline_enable (scanline_enable),
        .read_data       (read_data),
        .read_address    (read_address),
        .video_out       (video_out),
        .hsync           (hsync),
        .vsync           (vsync),
        .draw_area       (draw_area),
        .restart         (restart)
    );

endmodule

//--- source/ram_to_video.sv
module ram_to_video #(
    parameter int line_length,
    parameter int ram_lines,
    parameter int h_total,
    parameter int h_visible,
    parameter int h_offset,
    parameter int h_sync_start,
    parameter int h_sync_width,
    parameter int v_total,
    parameter int v_visible,
    parameter int v_offset,
    parameter int v_sync_line,
    localparam int address_bits = $clog2(line_length * ram_lines)
) (
    input  logic                               clock,
    input  logic                               combined_reset,
    input  logic                               start_trigger,
    input  logic                               line_doubler,
    input  logic                               scanline_enable,
    input  logic [video_pkg::pixel_width-1:0]  read_data,
    output logic [address_bits-1:0]            read_address,
    output logic [video_pkg::pixel_width-1:0]  video_out,
    output logic                               hsync,
    output logic                               vsync,
    output logic                               draw_area,
    output logic                               restart
);

    localparam int words    = line_length * ram_lines;
    localparam int x_bits   = $clog2(h_total);
    localparam int y_bits   = $clog2(v_total);
    localparam int channels = video_pkg::pixel_width / video_pkg::channel_width;

    localparam logic [address_bits-1:0] line_step     = address_bits'(line_length);
    localparam logic [address_bits-1:0] last_row_base = address_bits'(words - line_length);
    // with doubling the first window line already shows row v_offset / 2
    localparam logic [address_bits-1:0] doubled_start =
        address_bits'(((v_offset / 2) % ram_lines) * line_length);

    logic doubler_q;
    logic doubler_q_q;
    logic doubler_edge;
    logic clear_state;

    logic running;     // trigger seen, counters live
    logic stage_valid; // x_q / y_q hold a live position

    logic [x_bits-1:0] x_count;
    logic [y_bits-1:0] y_count;
    logic [x_bits-1:0] x_q;
    logic [y_bits-1:0] y_q;

    logic [address_bits-1:0] addr_x;
    logic [address_bits-1:0] addr_y; // base of the current buffer row
    logic                    line_advance;

    function automatic logic in_window(input logic [x_bits-1:0] x, input logic [y_bits-1:0] y);
        return x >= h_offset && x < h_visible - h_offset
            && y >= v_offset && y < v_visible - v_offset;
    endfunction

    function automatic logic [video_pkg::pixel_width-1:0] halve_channels(
        input logic [video_pkg::pixel_width-1:0] pixel
    );
        logic [video_pkg::pixel_width-1:0] result;
        for (int i = 0; i < channels; i++) begin
            result[i*video_pkg::channel_width +: video_pkg::channel_width] =
                pixel[i*video_pkg::channel_width +: video_pkg::channel_width] >> 1;
        end
        return result;
    endfunction

    // any toggle of the doubler setting restarts the consumer
    always_ff @(posedge clock) begin
        doubler_q   <= line_doubler;
        doubler_q_q <= doubler_q;
    end

    assign doubler_edge = doubler_q ^ doubler_q_q;
    assign clear_state  = combined_reset || doubler_edge;

    // doubled lines move on only after odd y
    assign line_advance = doubler_q ? y_count[0] : (y_count >= v_offset);

    assign read_address = in_window(x_count, y_count) ? addr_y + addr_x : '0;

    always_ff @(posedge clock) begin
        if (clear_state) begin
            running <= 1'b0;
            restart <= 1'b0;
            x_count <= x_bits'(h_offset);
            y_count <= y_bits'(v_offset);
            addr_x  <= '0;
            addr_y  <= '0;
        end else if (!running) begin
            restart <= start_trigger;
            if (start_trigger) begin
                running <= 1'b1;
                x_count <= x_bits'(h_offset);
                y_count <= y_bits'(v_offset);
                addr_x  <= '0;
                addr_y  <= doubler_q ? doubled_start : '0;
            end
        end else begin
            restart <= 1'b0;
            if (x_count < h_total - 1) begin
                x_count <= x_count + 1'b1;
                if (x_count >= h_offset && addr_x < line_length - 1) begin
                    addr_x <= addr_x + 1'b1;
                end else begin
                    addr_x <= '0;
                end
            end else begin
                x_count <= '0;
                addr_x  <= '0;
                if (y_count < v_total - 1) begin
                    y_count <= y_count + 1'b1;
                    if (line_advance) begin
                        // rows wrap around the buffer
                        addr_y <= (addr_y == last_row_base) ? '0 : addr_y + line_step;
                    end
                end else begin
                    y_count <= '0;
                    addr_y  <= '0;
                end
            end
        end
    end

    // position lines up with read_data here
    always_ff @(posedge clock) begin
        if (clear_state) begin
            stage_valid <= 1'b0;
        end else begin
            stage_valid <= running;
        end
    end

    always_ff @(posedge clock) begin
        x_q <= x_count;
        y_q <= y_count;
    end

    always_ff @(posedge clock) begin
        if (clear_state || !stage_valid) begin
            draw_area <= 1'b0;
            hsync     <= ~video_pkg::sync_active;
            vsync     <= ~video_pkg::sync_active;
            video_out <= '0;
        end else begin
            draw_area <= x_q < h_visible && y_q < v_visible;

            if (x_q >= h_sync_start && x_q < h_sync_start + h_sync_width) begin
                hsync <= video_pkg::sync_active;
            end else begin
                hsync <= ~video_pkg::sync_active;
            end

            vsync <= (y_q == v_sync_line) ? video_pkg::sync_active : ~video_pkg::sync_active;

            if (!in_window(x_q, y_q)) begin
                video_out <= '0; // border
            end else if (scanline_enable && y_q[0]) begin
                video_out <= halve_channels(read_data);
            end else begin
                video_out <= read_data;
            end
        end
    end

endmodule

//--- source/frame_ram.sv
module frame_ram #(
    parameter int line_length,
    parameter int ram_lines,
    localparam int address_bits = $clog2(line_length * ram_lines)
) (
    input  logic                               clock,
    input  logic                               write_enable,
    input  logic [address_bits-1:0]            write_address,
    input  logic [video_pkg::pixel_width-1:0]  write_data,
    input  logic [address_bits-1:0]            read_address,
    output logic [video_pkg::pixel_width-1:0]  read_data
);

    localparam int words = line_length * ram_lines;

    logic [video_pkg::pixel_width-1:0] memory [words];

    always_ff @(posedge clock) begin
        if (write_enable) begin
            memory[write_address] <= write_data;
        end
        read_data <= memory[read_address]; // one cycle read latency
    end

endmodule

//--- source/pixel_writer.sv
module pixel_writer #(
    parameter int line_length,
    parameter int ram_lines,
    localparam int address_bits = $clog2(line_length * ram_lines)
) (
    input  logic                               clock,
    input  logic                               combined_reset,
    input  logic                               pixel_strobe,
    input  logic [video_pkg::pixel_width-1:0]  pixel_data,
    input  logic                               frame_start,
    output logic                               write_enable,
    output logic [address_bits-1:0]            write_address,
    output logic [video_pkg::pixel_width-1:0]  write_data,
    output logic                               start_trigger
);

    localparam int words = line_length * ram_lines;

    logic [address_bits-1:0] next_address;
    logic [address_bits-1:0] base_address;
    logic [address_bits-1:0] line_count; // writes seen since frame_start
    logic                    counting;

    // a pixel strobed together with frame_start lands at address 0
    assign base_address = frame_start ? '0 : next_address;

    always_ff @(posedge clock) begin
        if (combined_reset) begin
            write_enable  <= 1'b0;
            next_address  <= '0;
            line_count    <= '0;
            counting      <= 1'b0;
            start_trigger <= 1'b0;
        end else begin
            write_enable  <= pixel_strobe;
            start_trigger <= 1'b0;

            if (pixel_strobe) begin
                next_address <= (base_address == words - 1) ? '0 : base_address + 1'b1;
            end else begin
                next_address <= base_address;
            end

            if (frame_start) begin
                counting   <= 1'b1;
                line_count <= '0;
            end else if (write_enable && counting) begin
                // this write completes the first line of the frame
                if (line_count == line_length - 1) begin
                    start_trigger <= 1'b1;
                    counting      <= 1'b0; // once per frame
                end else begin
                    line_count <= line_count + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (pixel_strobe) begin
            write_address <= base_address;
            write_data    <= pixel_data;
        end
    end

endmodule

//--- source/video_pkg.sv
package video_pkg;

    // one RGB pixel with red in the top byte
    localparam int pixel_width = 24;

    // one colour channel
    localparam int channel_width = 8;

    // hsync and vsync are active low
    localparam logic sync_active = 1'b0;

endpackage

//--- include/video_geometry.svh
`ifndef VIDEO_GEOMETRY_SVH
`define VIDEO_GEOMETRY_SVH

// tiny raster so a whole frame fits in a short simulation

// horizontal timing in counts per line
`define h_total      16
`define h_visible    12
`define h_offset     2
`define h_sync_start 12
`define h_sync_width 2

// vertical timing in lines per frame
`define v_total      12
`define v_visible    10
`define v_offset     1
`define v_sync_line  10

// frame buffer shape
`define line_length  8
`define ram_lines    8

`endif
